// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal -f flist.f --top-module tb_soc -Mdir obj_dir
	@out="$$(./obj_dir/Vtb_soc)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf obj_dir

// File: bus_decoder.sv
`timescale 1ns/100ps

module bus_decoder #(
    parameter int ram_words = 256
) (
    input  logic                           clk,
    input  logic                           rst_n,
    soc_bus_if.target                      bus,
    output logic                           ram_en,
    output logic                           ram_wen,
    output logic [$clog2(ram_words)-1:0]   ram_addr,
    output logic [bus_pkg::data_w-1:0]     ram_wdata,
    output logic [bus_pkg::data_w/8-1:0]   ram_byte_sel,
    input  logic [bus_pkg::data_w-1:0]     ram_rdata,
    output bus_pkg::region_e               io_sel,
    output logic                           io_wen,
    output logic [bus_pkg::data_w-1:0]     io_wdata,
    input  logic [bus_pkg::data_w-1:0]     io_rdata
);

    bus_pkg::region_e region;
    logic             is_write;
    logic             ram_read;
    logic             io_read;
    logic             bad;
    logic             rd_pend;

    // address map lookup
    always_comb begin
        if (bus.addr < bus_pkg::ram_limit) begin
            region = bus_pkg::region_ram;
        end else if (bus.addr == bus_pkg::timer_addr) begin
            region = bus_pkg::region_timer;
        end else if (bus.addr == bus_pkg::buttons_addr) begin
            region = bus_pkg::region_buttons;
        end else if (bus.addr == bus_pkg::leds_addr) begin
            region = bus_pkg::region_leds;
        end else begin
            region = bus_pkg::region_none;
        end
    end

    assign is_write = (bus.wen == bus_pkg::op_write);
    assign ram_read = (region == bus_pkg::region_ram) && !is_write;
    assign io_read  = !is_write && (region == bus_pkg::region_timer ||
                                    region == bus_pkg::region_buttons ||
                                    region == bus_pkg::region_leds);
    // unmapped, or a write to a read-only register
    assign bad = (region == bus_pkg::region_none) ||
                 (is_write && (region == bus_pkg::region_timer ||
                               region == bus_pkg::region_buttons));

    // ram strobes, word addressed
    assign ram_en       = bus.valid && (region == bus_pkg::region_ram);
    assign ram_wen      = ram_en && is_write;
    assign ram_addr     = bus.addr[$clog2(ram_words)+1:2];
    assign ram_wdata    = bus.wdata;
    assign ram_byte_sel = bus.byte_sel;

    // io side filters on io_sel itself
    assign io_sel   = region;
    assign io_wen   = bus.valid && is_write && (region != bus_pkg::region_ram);
    assign io_wdata = bus.wdata;

    // completion, one extra cycle for ram reads
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bus.done <= 1'b0;
            bus.err  <= 1'b0;
            rd_pend  <= 1'b0;
        end else begin
            bus.done <= 1'b0;
            rd_pend  <= 1'b0;
            if (rd_pend) begin
                bus.done <= 1'b1;
                bus.err  <= 1'b0;
            end else if (bus.valid) begin
                if (ram_read) begin
                    rd_pend <= 1'b1;
                end else begin
                    bus.done <= 1'b1;
                    bus.err  <= bad;
                end
            end
        end
    end

    // returned word; writes and errors give zero
    always_ff @(posedge clk) begin
        if (rd_pend) begin
            bus.rdata <= ram_rdata;
        end else if (bus.valid && !ram_read) begin
            bus.rdata <= io_read ? io_rdata : '0;
        end
    end

endmodule

// File: bus_pkg.sv
package bus_pkg;

    // host bus geometry
    parameter int addr_w = 16;
    parameter int data_w = 32;

    // byte address map
    // ram sits at the bottom, single-word registers up high
    parameter logic [addr_w-1:0] ram_limit    = 16'h0400;
    parameter logic [addr_w-1:0] timer_addr   = 16'h8000;
    parameter logic [addr_w-1:0] buttons_addr = 16'h8004;
    parameter logic [addr_w-1:0] leds_addr    = 16'h8008;

    // transaction kind
    typedef enum logic {
        op_read  = 1'b0,
        op_write = 1'b1
    } bus_op_e;

    // decoded target of one access
    typedef enum logic [2:0] {
        region_ram     = 3'd0,
        region_timer   = 3'd1,
        region_buttons = 3'd2,
        region_leds    = 3'd3,
        region_none    = 3'd4
    } region_e;

endpackage

// File: data_ram.sv
`timescale 1ns/100ps

module data_ram #(
    parameter int ram_words = 256
) (
    input  logic                           clk,
    input  logic                           en,
    input  logic                           wen,
    input  logic [$clog2(ram_words)-1:0]   addr,
    input  logic [bus_pkg::data_w-1:0]     wdata,
    input  logic [bus_pkg::data_w/8-1:0]   byte_sel,
    output logic [bus_pkg::data_w-1:0]     rdata
);

    // word storage
    logic [bus_pkg::data_w-1:0] mem [ram_words];

    // write lanes individually
    always_ff @(posedge clk) begin
        if (en && wen) begin
            for (int i = 0; i < bus_pkg::data_w / 8; i++) begin
                if (byte_sel[i]) begin
                    mem[addr][i*8 +: 8] <= wdata[i*8 +: 8];
                end
            end
        end
    end

    // registered read, valid the cycle after en
    // output holds between reads
    always_ff @(posedge clk) begin
        if (en && !wen) begin
            rdata <= mem[addr];
        end
    end

endmodule

// File: flist.f
bus_pkg.sv
periph_pkg.sv
soc_bus_if.sv
reset_sync.sv
host_port.sv
bus_decoder.sv
data_ram.sv
io_regs.sv
soc_top.sv
tb_soc.sv

// File: host_port.sv
`timescale 1ns/100ps

module host_port (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           req,
    input  logic                           wen,
    input  logic [bus_pkg::addr_w-1:0]     addr,
    input  logic [bus_pkg::data_w-1:0]     wdata,
    input  logic [bus_pkg::data_w/8-1:0]   byte_sel,
    output logic                           ack,
    output logic [bus_pkg::data_w-1:0]     rdata,
    output logic                           err,
    soc_bus_if.initiator                   bus
);

    periph_pkg::port_state_e state;

    // latched request, held for the whole transaction
    bus_pkg::bus_op_e                 wen_q;
    logic [bus_pkg::addr_w-1:0]       addr_q;
    logic [bus_pkg::data_w-1:0]       wdata_q;
    logic [bus_pkg::data_w/8-1:0]     byte_sel_q;

    // control side
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= periph_pkg::st_idle;
            bus.valid <= 1'b0;
            ack       <= 1'b0;
            err       <= 1'b0;
        end else begin
            // valid is a single pulse
            bus.valid <= 1'b0;
            case (state)
                periph_pkg::st_idle: begin
                    if (req) begin
                        bus.valid <= 1'b1;
                        state     <= periph_pkg::st_busy;
                    end
                end
                periph_pkg::st_busy: begin
                    // ack goes up the cycle after done
                    if (bus.done) begin
                        ack   <= 1'b1;
                        err   <= bus.err;
                        state <= periph_pkg::st_ack;
                    end
                end
                periph_pkg::st_ack: begin
                    // master may hold req; wait it out
                    if (!req) begin
                        ack   <= 1'b0;
                        state <= periph_pkg::st_idle;
                    end
                end
                default: state <= periph_pkg::st_idle;
            endcase
        end
    end

    // payload capture
    always_ff @(posedge clk) begin
        if (state == periph_pkg::st_idle && req) begin
            wen_q      <= wen ? bus_pkg::op_write : bus_pkg::op_read;
            addr_q     <= addr;
            wdata_q    <= wdata;
            byte_sel_q <= byte_sel;
        end
        if (state == periph_pkg::st_busy && bus.done) begin
            rdata <= bus.rdata;
        end
    end

    assign bus.wen      = wen_q;
    assign bus.addr     = addr_q;
    assign bus.wdata    = wdata_q;
    assign bus.byte_sel = byte_sel_q;

endmodule

// File: io_regs.sv
`timescale 1ns/100ps

module io_regs #(
    parameter int timer_div = 4
) (
    input  logic                              clk,
    input  logic                              rst_n,
    input  bus_pkg::region_e                  sel,
    input  logic                              wen,
    input  logic [bus_pkg::data_w-1:0]        wdata,
    output logic [bus_pkg::data_w-1:0]        rdata,
    input  logic [periph_pkg::btn_w-1:0]      buttons,
    output logic [periph_pkg::led_w-1:0]      leds
);

    // at least one prescaler bit, even for a ratio of 1
    localparam int presc_w = (timer_div > 1) ? $clog2(timer_div) : 1;

    logic [presc_w-1:0]              presc;
    logic [periph_pkg::timer_w-1:0]  timer;
    logic [periph_pkg::btn_w-1:0]    btn_meta;
    logic [periph_pkg::btn_w-1:0]    btn_sync;

    // prescaler wraps at timer_div, timer steps on the wrap
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            presc <= '0;
            timer <= '0;
        end else if (presc == presc_w'(timer_div - 1)) begin
            presc <= '0;
            timer <= timer + 1'b1;
        end else begin
            presc <= presc + 1'b1;
        end
    end

    // two flops against metastability
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            btn_meta <= '0;
            btn_sync <= '0;
        end else begin
            btn_meta <= buttons;
            btn_sync <= btn_meta;
        end
    end

    // led register, low byte of the write
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            leds <= '0;
        end else if (wen && sel == bus_pkg::region_leds) begin
            leds <= wdata[periph_pkg::led_w-1:0];
        end
    end

    // read mux
    always_comb begin
        case (sel)
            bus_pkg::region_timer:   rdata = bus_pkg::data_w'(timer);
            bus_pkg::region_buttons: rdata = bus_pkg::data_w'(btn_sync);
            bus_pkg::region_leds:    rdata = bus_pkg::data_w'(leds);
            default:                 rdata = '0;
        endcase
    end

endmodule

// File: periph_pkg.sv
package periph_pkg;

    // free-running timer register
    parameter int timer_w = 32;

    // button inputs, one bit each
    parameter int btn_w = 4;

    // led output register
    parameter int led_w = 8;

    // host port handshake phases
    typedef enum logic [1:0] {
        st_idle = 2'd0,
        st_busy = 2'd1,
        st_ack  = 2'd2
    } port_state_e;

endpackage

// File: reset_sync.sv
`timescale 1ns/100ps

module reset_sync #(
    parameter int reset_cycles = 4
) (
    input  logic clk,
    input  logic ext_reset,
    output logic rst_n
);

    logic [reset_cycles-1:0] cnt;

    // cleared straight away, counts up to all ones then holds
    always_ff @(posedge clk or negedge ext_reset) begin
        if (!ext_reset) begin
            cnt <= '0;
        end else if (!rst_n) begin
            cnt <= cnt + 1'b1;
        end
    end

    // release once saturated
    assign rst_n = &cnt;

endmodule

// File: soc_bus_if.sv
`timescale 1ns/100ps

interface soc_bus_if;

    // request side, from host port
    logic                             valid;
    bus_pkg::bus_op_e                 wen;
    logic [bus_pkg::addr_w-1:0]       addr;
    logic [bus_pkg::data_w-1:0]       wdata;
    logic [bus_pkg::data_w/8-1:0]     byte_sel;

    // response side, from decoder
    // rdata and err only meaningful while done is high
    logic [bus_pkg::data_w-1:0]       rdata;
    logic                             err;
    logic                             done;

    modport initiator (
        output valid, wen, addr, wdata, byte_sel,
        input  rdata, err, done
    );

    modport target (
        input  valid, wen, addr, wdata, byte_sel,
        output rdata, err, done
    );

endinterface

// File: soc_top.sv
`timescale 1ns/100ps

module soc_top #(
    parameter int ram_words    = 256,
    parameter int timer_div    = 4,
    parameter int reset_cycles = 4
) (
    input  logic                              clk,
    input  logic                              ext_reset,
    input  logic                              req,
    output logic                              ack,
    input  logic                              wen,
    input  logic [bus_pkg::addr_w-1:0]        addr,
    input  logic [bus_pkg::data_w-1:0]        wdata,
    input  logic [bus_pkg::data_w/8-1:0]      byte_sel,
    output logic [bus_pkg::data_w-1:0]        rdata,
    output logic                              err,
    input  logic [periph_pkg::btn_w-1:0]      buttons,
    output logic [periph_pkg::led_w-1:0]      leds
);

    logic                              rst_n;

    // decoder to ram
    logic                              ram_en;
    logic                              ram_wen;
    logic [$clog2(ram_words)-1:0]      ram_addr;
    logic [bus_pkg::data_w-1:0]        ram_wdata;
    logic [bus_pkg::data_w/8-1:0]      ram_byte_sel;
    logic [bus_pkg::data_w-1:0]        ram_rdata;

    // decoder to io registers
    bus_pkg::region_e                  io_sel;
    logic                              io_wen;
    logic [bus_pkg::data_w-1:0]        io_wdata;
    logic [bus_pkg::data_w-1:0]        io_rdata;

    soc_bus_if bus_if ();

    reset_sync #(.reset_cycles(reset_cycles)) i_reset_sync (
        .clk       (clk),
        .ext_reset (ext_reset),
        .rst_n     (rst_n)
    );

    // input side
    host_port i_host_port (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (req),
        .wen       (wen),
        .addr      (addr),
        .wdata     (wdata),
        .byte_sel  (byte_sel),
        .ack       (ack),
        .rdata     (rdata),
        .err       (err),
        .bus       (bus_if.initiator)
    );

    // address decode
    bus_decoder #(.ram_words(ram_words)) i_bus_decoder (
        .clk          (clk),
        .rst_n        (rst_n),
        .bus          (bus_if.target),
        .ram_en       (ram_en),
        .ram_wen      (ram_wen),
        .ram_addr     (ram_addr),
        .ram_wdata    (ram_wdata),
        .ram_byte_sel (ram_byte_sel),
        .ram_rdata    (ram_rdata),
        .io_sel       (io_sel),
        .io_wen       (io_wen),
        .io_wdata     (io_wdata),
        .io_rdata     (io_rdata)
    );

    data_ram #(.ram_words(ram_words)) i_data_ram (
        .clk      (clk),
        .en       (ram_en),
        .wen      (ram_wen),
        .addr     (ram_addr),
        .wdata    (ram_wdata),
        .byte_sel (ram_byte_sel),
        .rdata    (ram_rdata)
    );

    // timer, buttons and leds
    io_regs #(.timer_div(timer_div)) i_io_regs (
        .clk     (clk),
        .rst_n   (rst_n),
        .sel     (io_sel),
        .wen     (io_wen),
        .wdata   (io_wdata),
        .rdata   (io_rdata),
        .buttons (buttons),
        .leds    (leds)
    );

endmodule

// File: tb_soc.sv
`timescale 1ns/100ps

module tb_soc;

    localparam int timer_div   = 4;
    localparam int reset_len   = 8;
    localparam int line_cycles = 40;

    logic                                clk;
    logic                                ext_reset;
    logic                                req;
    logic                                ack;
    logic                                wen;
    logic [bus_pkg::addr_w-1:0]          addr;
    logic [bus_pkg::data_w-1:0]          wdata;
    logic [bus_pkg::data_w/8-1:0]        byte_sel;
    logic [bus_pkg::data_w-1:0]          rdata;
    logic                                err;
    logic [periph_pkg::btn_w-1:0]        buttons;
    logic [periph_pkg::led_w-1:0]        leds;

    // one entry per access line of the stimulus file
    bus_pkg::bus_op_e                    stim_op[$];
    logic [bus_pkg::addr_w-1:0]          stim_addr[$];
    logic [bus_pkg::data_w-1:0]          stim_wdata[$];
    logic [bus_pkg::data_w/8-1:0]        stim_bsel[$];
    logic [periph_pkg::btn_w-1:0]        stim_btn[$];
    logic [bus_pkg::data_w-1:0]          stim_rdata[$];
    logic                                stim_err[$];
    int                                  stim_chk[$];

    logic [31:0] lfsr;
    int          cycle = 0;
    int          limit = 0;
    int          ack_cycle;
    // previous timer sample
    logic        have_timer = 1'b0;
    logic [31:0] prev_timer;
    int          prev_cycle;

    soc_top i_dut (
        .clk       (clk),
        .ext_reset (ext_reset),
        .req       (req),
        .ack       (ack),
        .wen       (wen),
        .addr      (addr),
        .wdata     (wdata),
        .byte_sel  (byte_sel),
        .rdata     (rdata),
        .err       (err),
        .buttons   (buttons),
        .leds      (leds)
    );

    always #10 clk = ~clk;

    // run length guard
    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (limit > 0 && cycle >= limit) begin
            $display("Timeout: the run went past %0d cycles without finishing", limit);
            $display("ERRORS FOUND");
            $fatal(1, "timeout");
        end
    end

    // fibonacci lfsr, taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // one lfsr step per bit taken
    task automatic draw_bits(input int n, output int val);
        val = 0;
        for (int k = 0; k < n; k++) begin
            lfsr = lfsr_step(lfsr);
            val  = (val << 1) | int'(lfsr[0]);
        end
    endtask

    task automatic fail_check(input string msg);
        $display("Fail at time %0t: %s", $time, msg);
        $display("ERRORS FOUND");
        $fatal(1, "check failed");
    endtask

    task automatic load_stimulus();
        int          fd;
        int          n;
        string       line;
        logic [31:0] col [8];
        fd = $fopen("tb_stimulus.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file tb_stimulus.txt");
            $display("ERRORS FOUND");
            $fatal(1, "no stimulus");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                // comment lines start with a hash
                if (line.len() > 0 && line.getc(0) != "#") begin
                    n = $sscanf(line, "%h %h %h %h %h %h %h %h", col[0], col[1],
                                col[2], col[3], col[4], col[5], col[6], col[7]);
                    if (n == 8) begin
                        stim_op.push_back(bus_pkg::bus_op_e'(col[0][0]));
                        stim_addr.push_back(col[1][bus_pkg::addr_w-1:0]);
                        stim_wdata.push_back(col[2]);
                        stim_bsel.push_back(col[3][bus_pkg::data_w/8-1:0]);
                        stim_btn.push_back(col[4][periph_pkg::btn_w-1:0]);
                        stim_rdata.push_back(col[5]);
                        stim_err.push_back(col[6][0]);
                        stim_chk.push_back(int'(col[7]));
                    end else if (n > 0) begin
                        $display("Malformed line in the stimulus file: %s", line);
                        $display("ERRORS FOUND");
                        $fatal(1, "bad stimulus");
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // increasing, and no faster than one step per timer_div cycles
    task automatic check_timer(input logic [31:0] value);
        logic [31:0] bound;
        assert (err === 1'b0) else fail_check("timer read returned err");
        if (have_timer) begin
            bound = 32'((ack_cycle - prev_cycle + timer_div - 1) / timer_div);
            assert (value > prev_timer)
                else fail_check($sformatf("timer %h not above %h", value, prev_timer));
            assert (value - prev_timer <= bound)
                else fail_check($sformatf("timer moved %0d steps, limit %0d",
                                          value - prev_timer, bound));
        end
        have_timer = 1'b1;
        prev_timer = value;
        prev_cycle = ack_cycle;
    endtask

    // one four-phase transfer, called on a falling edge
    task automatic run_access(input int i);
        int                          gap;
        int                          hold;
        logic [bus_pkg::data_w-1:0]  held_rdata;
        logic                        held_err;
        // buttons get through both sync flops first
        buttons = stim_btn[i];
        repeat (3) @(negedge clk);
        draw_bits(2, gap);
        repeat (gap) @(negedge clk);
        assert (ack === 1'b0) else fail_check("ack still high before a new request");
        wen      = (stim_op[i] == bus_pkg::op_write);
        addr     = stim_addr[i];
        wdata    = stim_wdata[i];
        byte_sel = stim_bsel[i];
        req      = 1'b1;
        do begin
            @(negedge clk);
        end while (ack !== 1'b1);
        ack_cycle  = cycle;
        held_rdata = rdata;
        held_err   = err;
        if (stim_chk[i] == 1) begin
            check_timer(held_rdata);
        end else begin
            assert (rdata === stim_rdata[i] && err === stim_err[i])
                else fail_check($sformatf("line %0d addr %h got %h err %b, expected %h err %b",
                                          i, stim_addr[i], rdata, err,
                                          stim_rdata[i], stim_err[i]));
        end
        if (stim_chk[i] == 2) begin
            assert (leds === stim_wdata[i][periph_pkg::led_w-1:0])
                else fail_check($sformatf("leds %h after writing %h", leds, stim_wdata[i]));
        end
        // master stalls, response must hold
        draw_bits(2, hold);
        repeat (hold) begin
            @(negedge clk);
            assert (ack === 1'b1 && rdata === held_rdata && err === held_err)
                else fail_check("response changed while req was held");
        end
        req = 1'b0;
        do begin
            @(negedge clk);
        end while (ack !== 1'b0);
    endtask

    initial begin
        clk       = 1'b0;
        ext_reset = 1'b0;
        req       = 1'b0;
        wen       = 1'b0;
        addr      = '0;
        wdata     = '0;
        byte_sel  = '0;
        buttons   = '0;
        lfsr      = 32'h69c4715e;
        load_stimulus();
        limit = line_cycles * stim_op.size() + reset_len;
        repeat (reset_len) @(negedge clk);
        ext_reset = 1'b1;
        assert (ack === 1'b0 && leds === '0) else fail_check("ack or leds not low after reset");
        for (int i = 0; i < stim_op.size(); i++) begin
            run_access(i);
        end
        $display("NO ERRORS");
        $finish;
    end

endmodule

// File: tb_stimulus.txt
# columns in hex: op addr wdata byte_sel buttons exp_rdata exp_err chk
# op 1 = write, chk 0 = compare rdata and err, 1 = timer read, 2 = LED write
1 0000 0badf00d f 0 00000000 0 0
1 0010 deadbeef f 0 00000000 0 0
0 0010 00000000 0 0 deadbeef 0 0
1 0014 11223344 f 0 00000000 0 0
1 0014 aabbccdd 1 0 00000000 0 0
1 0014 55667788 4 0 00000000 0 0
0 0014 00000000 0 0 116633dd 0 0
1 0014 99aabbcc a 0 00000000 0 0
0 0014 00000000 0 0 9966bbdd 0 0
0 0400 00000000 0 0 00000000 1 0
1 0400 cafef00d f 0 00000000 1 0
1 8000 12345678 f 0 00000000 1 0
1 8004 87654321 f 0 00000000 1 0
0 0000 00000000 0 0 0badf00d 0 0
0 800c 00000000 0 0 00000000 1 0
1 9010 a5a5a5a5 f 0 00000000 1 0
0 0010 00000000 0 0 deadbeef 0 0
0 8004 00000000 0 a 0000000a 0 0
0 8004 00000000 0 5 00000005 0 0
1 8008 123456a5 f 0 00000000 0 2
0 8008 00000000 0 0 000000a5 0 0
1 8008 ffffff3c 3 0 00000000 0 2
0 8008 00000000 0 0 0000003c 0 0
0 8000 00000000 0 0 00000000 0 1
0 8000 00000000 0 0 00000000 0 1
0 8000 00000000 0 0 00000000 0 1
